// File: verilog.f
rtl/cache_pkg.sv
rtl/cache_store.sv
rtl/cache_ctrl.sv
rtl/main_mem.sv
rtl/cache_subsys.sv
dv/tb_clk_gen.sv
dv/cache_tb.sv

// File: Bender.yml
package:
  name: cache_subsys

sources:
  - rtl/cache_pkg.sv
  - rtl/cache_store.sv
  - rtl/cache_ctrl.sv
  - rtl/main_mem.sv
  - rtl/cache_subsys.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/cache_tb.sv

// File: dv/cache_tb.sv
`timescale 1ns/1ps
/* cache_tb
   drives cache_subsys with directed and random requests, tracks memory
   and tag shadows, and checks results with concurrent assertions */
module cache_tb
  import cache_pkg::*;
();

  localparam int num_random = 200;
  localparam int max_reqs   = num_random + 40;
  localparam int wd_cycles  = max_reqs * (4 + mem_lat) + max_reqs * 4 + 100;
  localparam int mem_words  = mem_blocks * (block_w / data_w);

  logic clk;
  logic rst;
  logic enable;
  logic wr_en;
  logic [addr_w-1:0] r_addr;
  logic [addr_w-1:0] w_addr;
  logic [data_w-1:0] data_in;
  logic [data_w-1:0] data_out;
  logic operation_complete;
  logic hit;

  // expectations of the request in flight
  logic req_go;
  logic outstanding;
  logic exp_wr;
  logic exp_hit;
  logic [data_w-1:0] exp_data;
  int exp_lat;
  int since_req;    // cycles since enable was sampled
  logic rst_q;

  logic [data_w-1:0] shadow_mem [mem_words];
  logic [num_lines-1:0] sh_valid;
  logic [tag_w-1:0] sh_tag [num_lines];

  int err_cnt;
  int tests_ok;
  int tests_bad;
  integer seed;

  tb_clk_gen i_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  cache_subsys i_dut (
    .clk                (clk),
    .rst                (rst),
    .enable             (enable),
    .wr_en              (wr_en),
    .r_addr             (r_addr),
    .w_addr             (w_addr),
    .data_in            (data_in),
    .data_out           (data_out),
    .operation_complete (operation_complete),
    .hit                (hit)
  );

  always @(posedge clk) begin
    rst_q <= rst;
    if (req_go) since_req <= 0;
    else since_req <= since_req + 1;
  end

  a_reset_quiet: assert property (@(posedge clk)
    rst_q |-> !operation_complete && !hit && (data_out == '0)
  ) else begin
    $display("ERR reset outputs operation_complete %h hit %h data_out %h",
             $sampled(operation_complete), $sampled(hit), $sampled(data_out));
    err_cnt++;
  end

  a_done_expected: assert property (@(posedge clk) disable iff (rst)
    operation_complete |-> outstanding
  ) else begin
    $display("operation_complete seen with no request in flight");
    err_cnt++;
  end

  a_latency: assert property (@(posedge clk) disable iff (rst)
    operation_complete |-> since_req == exp_lat
  ) else begin
    $display("request completed after %0d cycles, expected %0d",
             $sampled(since_req), $sampled(exp_lat));
    err_cnt++;
  end

  a_hit_flag: assert property (@(posedge clk) disable iff (rst)
    operation_complete |-> hit == exp_hit
  ) else begin
    $display("ERR hit got %h exp %h", $sampled(hit), $sampled(exp_hit));
    err_cnt++;
  end

  a_read_data: assert property (@(posedge clk) disable iff (rst)
    operation_complete && !exp_wr |-> data_out == exp_data
  ) else begin
    $display("ERR data_out got %h exp %h", $sampled(data_out), $sampled(exp_data));
    err_cnt++;
  end

  // word index in the memory shadow, wrapped like the memory
  function automatic int word_idx(input logic [addr_w-1:0] a);
    return int'((a >> (off_w - word_sel_w)) % mem_words);
  endfunction

  function automatic int line_idx(input logic [addr_w-1:0] a);
    return int'((a >> off_w) % num_lines);
  endfunction

  function automatic logic [tag_w-1:0] tag_of(input logic [addr_w-1:0] a);
    return tag_w'(a >> (off_w + idx_w));
  endfunction

  function automatic logic predict_hit(input logic [addr_w-1:0] a);
    int i;
    i = line_idx(a);
    return sh_valid[i] && (sh_tag[i] == tag_of(a));
  endfunction

  // one request; stray adds an enable pulse while the cache is busy
  task automatic do_request(input logic wr, input logic [addr_w-1:0] a,
                            input logic [data_w-1:0] d, input logic stray);
    logic              hit_pred;
    logic [data_w-1:0] val_pred;
    int                lat;
    int                waited;
    hit_pred = predict_hit(a);
    val_pred = shadow_mem[word_idx(a)];
    if (wr) begin
      lat = 3 + mem_lat;
      shadow_mem[word_idx(a)] = d;  // write-through, no allocate
    end else if (hit_pred) begin
      lat = 2;
    end else begin
      lat = 4 + mem_lat;
      sh_valid[line_idx(a)] = 1'b1;
      sh_tag[line_idx(a)]   = tag_of(a);
    end
    @(posedge clk);
    enable      <= 1'b1;
    wr_en       <= wr;
    r_addr      <= wr ? ~a : a;
    w_addr      <= wr ? a : ~a;
    data_in     <= d;
    req_go      <= 1'b1;
    outstanding <= 1'b1;
    exp_wr      <= wr;
    exp_hit     <= hit_pred;
    exp_data    <= val_pred;
    exp_lat     <= lat;
    @(posedge clk);
    enable <= 1'b0;
    req_go <= 1'b0;
    if (stray) begin
      @(posedge clk);
      enable  <= 1'b1;
      wr_en   <= ~wr;
      r_addr  <= a ^ 64'h8000;  // conflicting tag, would evict if taken
      w_addr  <= a ^ 64'h8000;
      data_in <= ~d;
      @(posedge clk);
      enable <= 1'b0;
    end
    waited = 0;
    while (!operation_complete && waited < lat + 4) begin
      @(posedge clk);
      waited++;
    end
    if (!operation_complete) begin
      $display("timeout waiting for operation_complete at address %h", a);
      err_cnt++;
    end
    outstanding <= 1'b0;
    @(posedge clk);
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      $display("test %s: ok", name);
      tests_ok++;
    end else begin
      $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
      tests_bad++;
    end
  endtask

  initial begin
    logic [addr_w-1:0] a0;
    logic [addr_w-1:0] b0;
    logic [addr_w-1:0] c0;
    logic [addr_w-1:0] ra;
    logic [31:0]       r;
    int                errs;
    enable      = 1'b0;
    wr_en       = 1'b0;
    r_addr      = '0;
    w_addr      = '0;
    data_in     = '0;
    req_go      = 1'b0;
    outstanding = 1'b0;
    exp_wr      = 1'b0;
    exp_hit     = 1'b0;
    exp_data    = '0;
    exp_lat     = 0;
    since_req   = 0;
    rst_q       = 1'b0;
    sh_valid    = '0;
    err_cnt     = 0;
    tests_ok    = 0;
    tests_bad   = 0;
    seed        = 32'hcbe7_fd9c;
    for (int i = 0; i < mem_words; i++) shadow_mem[i] = '0;
    a0 = 64'h1048;                  // line 65, word 1
    b0 = a0 + (64'd1 << (off_w + idx_w));  // same line, other tag
    c0 = 64'h2100;                  // line 132

    errs = err_cnt;
    @(posedge clk);
    while (rst) @(posedge clk);
    repeat (2) @(posedge clk);
    report_test("reset", errs);

    errs = err_cnt;
    do_request(1'b1, a0, 64'h0123_4567_89ab_cdef, 1'b0);
    do_request(1'b1, a0 + 64'h28, 64'hfeed_face_0bad_f00d, 1'b0);
    do_request(1'b0, a0, '0, 1'b0);
    report_test("write then read-miss fill", errs);

    errs = err_cnt;
    for (int w = 0; w < 8; w++) begin
      do_request(1'b0, (a0 & ~64'h3f) | (64'(w) << 3), '0, w[0]);
    end
    report_test("read hit", errs);

    errs = err_cnt;
    do_request(1'b0, b0, '0, 1'b0);
    do_request(1'b0, a0, '0, 1'b0);
    do_request(1'b0, b0, '0, 1'b1);
    report_test("conflict eviction", errs);

    errs = err_cnt;
    do_request(1'b1, b0, 64'h5a5a_0000_ffff_a5a5, 1'b0);  // line holds b0
    do_request(1'b0, b0, '0, 1'b0);
    do_request(1'b1, c0, 64'h0000_1111_2222_3333, 1'b1);
    do_request(1'b0, c0, '0, 1'b0);
    report_test("write hit and write miss", errs);

    errs = err_cnt;
    for (int n = 0; n < num_random; n++) begin
      r  = $random(seed);
      // 4 lines, 2 tags, 8 words
      ra = (64'(r[2]) << (off_w + idx_w)) | (64'(r[1:0] + 40) << off_w)
         | (64'(r[5:3]) << 3);
      do_request(r[8], ra, {$random(seed), $random(seed)}, r[11:10] == 2'b00);
    end
    report_test("random mix", errs);

    $display("tests passed %0d failed %0d, errors %0d", tests_ok, tests_bad, err_cnt);
    if (tests_bad == 0 && err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    repeat (wd_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not finish", wd_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps
/* tb_clk_gen
   testbench clock (40 ns period) and synchronous reset for 4 cycles */
module tb_clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: rtl/cache_subsys.sv
`timescale 1ns/1ps
/* cache_subsys
   write-through cache subsystem: controller, cache arrays and main memory */
module cache_subsys
  import cache_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              enable,
  input  logic              wr_en,
  input  logic [addr_w-1:0] r_addr,
  input  logic [addr_w-1:0] w_addr,
  input  logic [data_w-1:0] data_in,
  output logic [data_w-1:0] data_out,
  output logic              operation_complete,
  output logic              hit
);

  // controller to cache arrays
  cache_addr_t        addr;
  logic               fill_en;
  logic               wr_word_en;
  logic [data_w-1:0]  wr_word;
  logic               line_hit;
  logic [data_w-1:0]  rd_word;

  // controller to memory
  cache_addr_t        mem_address;
  logic [data_w-1:0]  mem_data_out;
  logic               mem_rd_en;
  logic               mem_wr_en;
  logic [block_w-1:0] mem_data_in;
  logic               mem_data_valid;

  cache_ctrl i_ctrl (
    .clk                (clk),
    .rst                (rst),
    .enable             (enable),
    .wr_en              (wr_en),
    .r_addr             (r_addr),
    .w_addr             (w_addr),
    .data_in            (data_in),
    .line_hit           (line_hit),
    .rd_word            (rd_word),
    .mem_data_valid     (mem_data_valid),
    .mem_data_in        (mem_data_in),
    .data_out           (data_out),
    .operation_complete (operation_complete),
    .hit                (hit),
    .addr               (addr),
    .fill_en            (fill_en),
    .wr_word_en         (wr_word_en),
    .wr_word            (wr_word),
    .mem_address        (mem_address),
    .mem_data_out       (mem_data_out),
    .mem_rd_en          (mem_rd_en),
    .mem_wr_en          (mem_wr_en)
  );

  cache_store i_store (
    .clk        (clk),
    .rst        (rst),
    .addr       (addr),
    .fill_en    (fill_en),
    .fill_block (mem_data_in),  // fill straight from the memory response
    .wr_word_en (wr_word_en),
    .wr_word    (wr_word),
    .line_hit   (line_hit),
    .rd_word    (rd_word)
  );

  main_mem i_mem (
    .clk            (clk),
    .rst            (rst),
    .mem_address    (mem_address),
    .mem_data_out   (mem_data_out),
    .mem_rd_en      (mem_rd_en),
    .mem_wr_en      (mem_wr_en),
    .mem_data_in    (mem_data_in),
    .mem_data_valid (mem_data_valid)
  );

endmodule

// File: rtl/main_mem.sv
`timescale 1ns/1ps
/* main_mem
   behavioural block memory, fixed response latency,
   block reads and single-word writes */
module main_mem
  import cache_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  cache_addr_t        mem_address,
  input  logic [data_w-1:0]  mem_data_out,
  input  logic               mem_rd_en,
  input  logic               mem_wr_en,
  output logic [block_w-1:0] mem_data_in,
  output logic               mem_data_valid
);

  logic [block_w-1:0] mem_q [mem_blocks] = '{default: '0};

  logic [lat_cnt_w-1:0]  cnt;     // nonzero while a request is pending
  logic [mem_idx_w-1:0]  blk;
  logic [mem_idx_w-1:0]  rd_blk;
  logic                  is_rd;
  logic [word_sel_w-1:0] word_sel;

  // block address wraps onto the array
  assign blk      = mem_address.raw[off_w +: mem_idx_w];
  assign word_sel = mem_address.f.offset[off_w-1 -: word_sel_w];

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt            <= '0;
      mem_data_valid <= 1'b0;
    end else begin
      mem_data_valid <= 1'b0;
      if (mem_rd_en || mem_wr_en) begin
        cnt <= lat_cnt_w'(mem_lat - 1);
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
        if (cnt == lat_cnt_w'(1)) begin
          mem_data_valid <= 1'b1;  // mem_lat cycles after the request
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_wr_en) begin
      mem_q[blk][word_sel*data_w +: data_w] <= mem_data_out;
    end
    if (mem_rd_en || mem_wr_en) begin
      rd_blk <= blk;
      is_rd  <= mem_rd_en;
    end
    if (is_rd && cnt == lat_cnt_w'(1)) begin
      mem_data_in <= mem_q[rd_blk];  // block goes out with the valid pulse
    end
  end

  a_no_overlap: assert property (
    @(posedge clk) disable iff (rst)
    (mem_rd_en || mem_wr_en) |-> (cnt == '0)
  ) else $error("memory request while another is pending");

endmodule

// File: rtl/cache_ctrl.sv
`timescale 1ns/1ps
/* cache_ctrl
   request FSM sequencing lookup, miss fill, write-through and completion */
module cache_ctrl
  import cache_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               enable,
  input  logic               wr_en,
  input  logic [addr_w-1:0]  r_addr,
  input  logic [addr_w-1:0]  w_addr,
  input  logic [data_w-1:0]  data_in,
  input  logic               line_hit,
  input  logic [data_w-1:0]  rd_word,
  input  logic               mem_data_valid,
  input  logic [block_w-1:0] mem_data_in,
  output logic [data_w-1:0]  data_out,
  output logic               operation_complete,
  output logic               hit,
  output cache_addr_t        addr,
  output logic               fill_en,
  output logic               wr_word_en,
  output logic [data_w-1:0]  wr_word,
  output cache_addr_t        mem_address,
  output logic [data_w-1:0]  mem_data_out,
  output logic               mem_rd_en,
  output logic               mem_wr_en
);

  logic [state_w-1:0] state;
  logic [state_w-1:0] state_nxt;

  cache_addr_t        addr_q;
  logic [data_w-1:0]  data_q;
  logic               wr_q;     // latched request kind
  logic               confirm;  // next lookup is the one that answers a read
  logic [data_w-1:0]  fill_word;

  assign addr         = addr_q;
  assign mem_address  = addr_q;
  assign wr_word      = data_q;
  assign mem_data_out = data_q;

  assign fill_en    = (state == st_wait_fill) && mem_data_valid;
  assign wr_word_en = (state == st_lookup) && wr_q && line_hit;

  // requested word inside the returning block
  assign fill_word = mem_data_in[addr_q.f.offset[off_w-1 -: word_sel_w]*data_w +: data_w];

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (enable) begin
          state_nxt = st_lookup;
        end
      end
      st_lookup: begin
        if (wr_q) begin
          state_nxt = st_write_mem;  // hit or miss, always goes through
        end else if (!line_hit) begin
          state_nxt = st_req_mem;
        end else if (confirm) begin
          state_nxt = st_done;
        end
      end
      st_req_mem:   state_nxt = st_wait_fill;
      st_wait_fill: begin
        if (mem_data_valid) begin
          state_nxt = st_lookup;
        end
      end
      st_write_mem: state_nxt = st_wait_write;
      st_wait_write: begin
        if (mem_data_valid) begin
          state_nxt = st_done;
        end
      end
      st_done: state_nxt = st_idle;
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state              <= st_idle;
      confirm            <= 1'b0;
      hit                <= 1'b0;
      data_out           <= '0;
      operation_complete <= 1'b0;
      mem_rd_en          <= 1'b0;
      mem_wr_en          <= 1'b0;
    end else begin
      state              <= state_nxt;
      operation_complete <= (state_nxt == st_done);
      mem_rd_en          <= (state == st_req_mem);   // one-cycle pulses
      mem_wr_en          <= (state == st_write_mem);

      if (state == st_idle) begin
        confirm <= 1'b0;
      end else if (fill_en || (state == st_lookup && !wr_q && line_hit)) begin
        confirm <= 1'b1;
      end

      if (state == st_lookup && !confirm) begin
        hit <= line_hit;  // first lookup only
      end

      if (state == st_lookup && !wr_q && line_hit && confirm) begin
        data_out <= rd_word;
      end
    end
  end

  // request is sampled only in idle
  always_ff @(posedge clk) begin
    if (state == st_idle && enable) begin
      addr_q.raw <= wr_en ? w_addr : r_addr;
      data_q     <= data_in;
      wr_q       <= wr_en;
    end
  end

  a_complete_pulse: assert property (
    @(posedge clk) disable iff (rst)
    operation_complete |=> !operation_complete
  ) else $error("operation_complete held longer than one cycle");

  a_mem_one_req: assert property (
    @(posedge clk) disable iff (rst)
    !(mem_rd_en && mem_wr_en)
  ) else $error("read and write request to memory together");

  // the filled line must serve the requested word on the next lookup
  a_fill_lands: assert property (
    @(posedge clk) disable iff (rst)
    fill_en |-> mem_data_valid ##1 (rd_word == $past(fill_word))
  ) else $error("fill without valid data or fill not visible in the line");

endmodule

// File: rtl/cache_store.sv
`timescale 1ns/1ps
/* cache_store
   valid, tag and block arrays of the cache with hit compare,
   word select, whole-line fill and in-place word update */
module cache_store
  import cache_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  cache_addr_t        addr,
  input  logic               fill_en,
  input  logic [block_w-1:0] fill_block,
  input  logic               wr_word_en,
  input  logic [data_w-1:0]  wr_word,
  output logic               line_hit,
  output logic [data_w-1:0]  rd_word
);

  logic [num_lines-1:0]  valid_q;
  logic [tag_w-1:0]      tag_q  [num_lines];
  logic [block_w-1:0]    data_q [num_lines];

  logic [block_w-1:0]    line;
  logic [word_sel_w-1:0] word_sel;

  assign line     = data_q[addr.f.index];
  assign word_sel = addr.f.offset[off_w-1 -: word_sel_w];

  assign line_hit = valid_q[addr.f.index] && (tag_q[addr.f.index] == addr.f.tag);
  assign rd_word  = line[word_sel*data_w +: data_w];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (fill_en) begin
      valid_q[addr.f.index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_en) begin
      data_q[addr.f.index] <= fill_block;
      tag_q[addr.f.index]  <= addr.f.tag;
    end else if (wr_word_en) begin
      data_q[addr.f.index][word_sel*data_w +: data_w] <= wr_word; // write-through hit
    end
  end

  // a word write only lands on a resident line, and reads back next cycle
  a_word_write_hits: assert property (
    @(posedge clk) disable iff (rst)
    wr_word_en |-> line_hit ##1 (rd_word == $past(wr_word))
  ) else $error("word write to a missing line or lost update");

endmodule

// File: rtl/cache_pkg.sv
/* cache_pkg
   geometry of the direct-mapped write-through cache, memory model
   constants, FSM encodings and the address union */
package cache_pkg;

  localparam int addr_w     = 64;
  localparam int data_w     = 64;
  localparam int block_w    = 512;
  localparam int num_lines  = 512;

  localparam int off_w      = 6;
  localparam int idx_w      = 9;
  localparam int tag_w      = addr_w - idx_w - off_w; // 49
  localparam int word_sel_w = 3;  // upper offset bits

  localparam int mem_lat    = 4;
  localparam int mem_blocks = 1024;
  localparam int mem_idx_w  = $clog2(mem_blocks);
  localparam int lat_cnt_w  = $clog2(mem_lat + 1);

  // controller states
  localparam int state_w = 3;
  localparam logic [state_w-1:0] st_idle       = 3'd0;
  localparam logic [state_w-1:0] st_lookup     = 3'd1;
  localparam logic [state_w-1:0] st_req_mem    = 3'd2;
  localparam logic [state_w-1:0] st_wait_fill  = 3'd3;
  localparam logic [state_w-1:0] st_write_mem  = 3'd4;
  localparam logic [state_w-1:0] st_wait_write = 3'd5;
  localparam logic [state_w-1:0] st_done       = 3'd6;

  // byte address, seen either flat or split into cache fields
  typedef union packed {
    logic [addr_w-1:0] raw;
    struct packed {
      logic [tag_w-1:0] tag;
      logic [idx_w-1:0] index;
      logic [off_w-1:0] offset;
    } f;
  } cache_addr_t;

endpackage
